// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_up
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+verilog
verilog/up_pkg.sv
verilog/up_controller.sv
verilog/up_datapath.sv
verilog/up_memory.sv
verilog/up_top.sv
verification/up_checker.sv
verification/tb_up.sv

// File: verification/tb_up.sv
`timescale 1ns/1ps
`include "up_macros.svh"

module tb_up;
   import up_pkg::*;

   localparam int TMO = 200;

   logic      clk;
   logic      nRst;
   logic      run;
   logic      intr;
   axil_req_t host_req;
   axil_rsp_t host_rsp;
   byte_t     mm [`UP_MEM_SIZE];    // Model memory
   byte_t     img [`UP_MEM_SIZE];   // Image loaded into the DUT
   byte_t     rr [4];
   byte_t     mpc;
   byte_t     msp;
   logic      mie;
   logic      looped;
   nibble_t   last_op;
   int        seed;
   int        other_errs;
   int        chk_errs;
   int        chk_reads;

   up_top u_up_top (
      .clk      (clk),
      .nRst     (nRst),
      .run      (run),
      .intr     (intr),
      .host_req (host_req),
      .host_rsp (host_rsp)
   );

   up_checker u_checker (
      .clk      (clk),
      .nRst     (nRst),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .image    (mm),
      .errors   (chk_errs),
      .reads    (chk_reads)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7FFF_FFFF;
      return r % n;
   endfunction

   function automatic byte_t rand_byte();
      int r;
      r = rand_below(256);
      return r[7:0];
   endfunction

   function automatic void put_nib(input int n, input nibble_t v);
      if (n[0]) begin
         mm[n[8:1]][3:0] = v;
      end else begin
         mm[n[8:1]][7:4] = v;   // Even nibble is the high half
      end
   endfunction

   function automatic void model_start();
      rr[0] = mm[0];
      rr[1] = mm[1];
      rr[2] = mm[2];
      rr[3] = mm[3];
      mpc   = `UP_PC_RESET;
      msp   = `UP_SP_RESET;
      mie   = 1'b0;
   endfunction

   // One instruction, returns its clock count
   function automatic int model_step();
      byte_t      here;
      byte_t      t;
      logic [1:0] i;
      nibble_t    op;
      int         cyc;
      here    = mpc;
      op      = mpc[0] ? mm[mpc >> 1][3:0] : mm[mpc >> 1][7:4];
      mpc     = mpc + 8'd1;
      last_op = op;
      i       = op[1:0];
      case (op)
         4'h0: rr[0] = rr[1] + rr[2];   // Results land in r0
         4'h1: rr[0] = rr[1] - rr[2];
         4'h2: rr[0] = rr[1] * rr[2];
         4'h3: rr[0] = ~(rr[1] & rr[2]);
         4'h4, 4'h5, 4'h6: begin
            t               = rr[i];
            rr[i]           = rr[i + 2'd1];
            rr[i + 2'd1]    = t;
         end
         4'h7: begin
            if (rr[1] == rr[2]) begin
               looped = (rr[3] == here);
               mpc    = rr[3];
            end
         end
         4'h8: begin
            msp = msp + 8'd1;
            mpc = mm[msp];
         end
         4'h9: begin
            mm[msp] = mpc;
            msp     = msp - 8'd1;
            mpc     = rr[3];
         end
         4'hA: begin
            msp   = msp + 8'd1;
            rr[2] = mm[msp];
         end
         4'hB: begin
            mm[msp] = rr[2];
            msp     = msp - 8'd1;
         end
         4'hC: rr[2] = mm[rr[3]];
         4'hD: mm[rr[3]] = rr[2];
         4'hE: rr[0] = mm[rr[0]];
         default: mie = ~mie;
      endcase
      case (op)
         4'h0, 4'h1, 4'h2, 4'h3, 4'h7, 4'hF: cyc = 3;
         4'h4, 4'h5, 4'h6, 4'h9, 4'hB:       cyc = 5;
         default:                            cyc = 4;
      endcase
      return cyc;
   endfunction

   function automatic int model_run(input int limit);
      int cyc;
      int n;
      cyc    = 0;
      n      = 0;
      looped = 1'b0;
      while (!looped && n < limit) begin
         cyc += model_step();
         n++;
      end
      return cyc;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic reset_dut();
      @(negedge clk);
      nRst = 1'b0;
      wait_cycles(2);
      nRst = 1'b1;
   endtask

   task automatic host_write(input byte_t a, input byte_t d);
      int   n;
      logic done;
      @(negedge clk);
      host_req.awvalid = 1'b1;
      host_req.awaddr  = a;
      host_req.wvalid  = 1'b1;
      host_req.wdata   = d;
      host_req.bready  = 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done && n < TMO) begin
         #1;
         done = host_rsp.awready && host_rsp.wready;   // Transfer on the next rising edge
         @(negedge clk);
         n++;
      end
      host_req.awvalid = 1'b0;
      host_req.wvalid  = 1'b0;
      if (!done) begin
         other_errs++;
         $display("Timeout waiting for the write handshake at address %h", a);
      end
      n    = 0;
      done = 1'b0;
      while (!done && n < TMO) begin
         #1;
         done = host_rsp.bvalid;
         @(negedge clk);
         n++;
      end
      host_req.bready = 1'b0;
      if (!done) begin
         other_errs++;
         $display("Timeout waiting for the write response at address %h", a);
      end
   endtask

   task automatic host_read(input byte_t a, input int limit);
      int   n;
      logic done;
      @(negedge clk);
      host_req.arvalid = 1'b1;
      host_req.araddr  = a;
      host_req.rready  = 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done && n < limit) begin
         #1;
         done = host_rsp.arready;
         @(negedge clk);
         n++;
      end
      host_req.arvalid = 1'b0;
      if (!done) begin
         other_errs++;
         $display("Timeout waiting for the read address handshake at %h", a);
      end
      n    = 0;
      done = 1'b0;
      while (!done && n < TMO) begin
         #1;
         done = host_rsp.rvalid;   // Checker compares the data
         @(negedge clk);
         n++;
      end
      host_req.rready = 1'b0;
      if (!done) begin
         other_errs++;
         $display("Timeout waiting for read data from address %h", a);
      end
   endtask

   task automatic load_image();
      for (int i = 0; i < `UP_MEM_SIZE; i++) begin
         host_write(i[7:0], img[i[7:0]]);
      end
   endtask

   task automatic readback_all();
      for (int i = 0; i < `UP_MEM_SIZE; i++) begin
         host_read(i[7:0], TMO);
      end
   endtask

   task automatic run_program(input int cycles);
      @(negedge clk);
      run = 1'b1;
      wait_cycles(cycles);
      run = 1'b0;
      wait_cycles(2);
   endtask

   task automatic arith_test();
      int    cyc;
      int    tries;
      int    nib;
      int    x;
      byte_t v;
      cyc    = 0;
      tries  = 0;
      looped = 1'b0;
      while (!looped && tries < 20) begin
         nib = 8;
         for (int k = 0; k < 6; k++) begin
            x = rand_below(7);
            put_nib(nib, x[3:0]);
            put_nib(nib + 1, 4'hD);   // Store r2 at r3
            nib += 2;
         end
         // Pops from bytes 0-2 set r3 to the jump's own nibble and r1 == r2
         put_nib(20, 4'hA);
         put_nib(21, 4'h6);
         put_nib(22, 4'hA);
         put_nib(23, 4'h5);
         put_nib(24, 4'hA);
         put_nib(25, 4'h7);
         v     = rand_byte();
         mm[0] = 8'd25;
         mm[1] = v;
         mm[2] = v;
         mm[3] = rand_byte();
         img   = mm;
         model_start();
         cyc = model_run(100);
         if (!looped) begin
            mm = img;   // Stores hit the code, try another
         end
         tries++;
      end
      if (!looped) begin
         other_errs++;
         $display("No terminating arithmetic program could be built");
      end
      reset_dut();
      load_image();
      run_program(5 + cyc + 20);
      readback_all();
   endtask

   task automatic flow_test();
      int cyc;
      mm[0]  = (rand_byte() & 8'h3F) | 8'h80;   // Address for opcode E
      mm[1]  = 8'd40;
      mm[2]  = rand_byte();
      mm[3]  = 8'd40;                           // Subroutine at nibble 40
      mm[4]  = 8'hB9;
      mm[5]  = 8'hAE;
      mm[6]  = 8'hC6;
      mm[7]  = 8'h70;
      mm[20] = 8'hCB;
      mm[21] = 8'hA8;
      mm[40] = 8'd14;                           // Nibble of the final jump
      img    = mm;
      model_start();
      cyc = model_run(50);
      if (!looped) begin
         other_errs++;
         $display("Model did not reach the final loop of the call test");
      end
      reset_dut();
      load_image();
      run_program(5 + cyc + 20);
      readback_all();
   endtask

   task automatic irq_test();
      int    n;
      byte_t m;
      m     = rand_byte();
      mm[0] = 8'hD8;   // Vector: store r2 at r3, return
      mm[1] = m;
      mm[2] = m;
      mm[3] = 8'd9;
      mm[4] = 8'hF7;   // Enable, then loop at nibble 9
      img   = mm;
      model_start();
      void'(model_run(20));
      if (mie) begin
         mm[msp] = mpc;
         msp     = msp - 8'd1;
         mpc     = `UP_INT_VECTOR;
         last_op = 4'h0;
         n       = 0;
         while (last_op != 4'h8 && n < 10) begin
            void'(model_step());
            n++;
         end
      end
      reset_dut();
      load_image();
      @(negedge clk);
      run = 1'b1;
      wait_cycles(14 + rand_below(20));
      intr = 1'b1;
      wait_cycles(10);
      intr = 1'b0;
      wait_cycles(40);
      run = 1'b0;
      wait_cycles(2);
      readback_all();
   endtask

   task automatic backpressure_test();
      byte_t a;
      a = rand_byte();
      reset_dut();
      @(negedge clk);
      run = 1'b1;
      wait_cycles(10);
      fork
         host_read(a, 2 * TMO);
         begin
            repeat (20) begin
               @(negedge clk);
               #1;
               if (host_rsp.arready) begin
                  other_errs++;
                  $display("FAIL arready: expected 0, got 1");
               end
            end
            @(negedge clk);
            run = 1'b0;
         end
      join
   endtask

   initial begin
      seed       = 14;
      other_errs = 0;
      nRst       = 1'b0;
      run        = 1'b0;
      intr       = 1'b0;
      host_req   = '0;
      wait_cycles(2);
      nRst = 1'b1;
      for (int i = 0; i < `UP_MEM_SIZE; i++) begin
         mm[i[7:0]] = rand_byte();
      end
      img = mm;
      load_image();
      readback_all();
      repeat (4) arith_test();
      repeat (2) flow_test();
      irq_test();
      backpressure_test();
      wait_cycles(4);
      $display("Errors: %0d data, %0d other, %0d reads checked",
               chk_errs, other_errs, chk_reads);
      if (chk_errs == 0 && other_errs == 0 && chk_reads > 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: verification/up_checker.sv
`timescale 1ns/1ps
`include "up_macros.svh"

module up_checker (
   input  logic              clk,
   input  logic              nRst,
   input  up_pkg::axil_req_t host_req,
   input  up_pkg::axil_rsp_t host_rsp,
   input  up_pkg::byte_t     image [`UP_MEM_SIZE],
   output int                errors,
   output int                reads
);
   import up_pkg::*;

   byte_t raddr   = '0;   // Address of the read in flight
   int    err_cnt = 0;
   int    rd_cnt  = 0;

   assign errors = err_cnt;
   assign reads  = rd_cnt;

   always @(posedge clk) begin
      if (nRst) begin
         if (host_req.arvalid && host_rsp.arready) begin
            raddr <= host_req.araddr;
         end
         if (host_rsp.rvalid && host_req.rready) begin
            rd_cnt <= rd_cnt + 1;
            if (host_rsp.rdata !== image[raddr]) begin
               err_cnt <= err_cnt + 1;
               $display("FAIL rdata at %h: expected %h, got %h",
                        raddr, image[raddr], host_rsp.rdata);
            end
            if (host_rsp.rresp !== 2'b00) begin
               err_cnt <= err_cnt + 1;
               $display("FAIL rresp: expected 0, got %h", host_rsp.rresp);
            end
         end
         if (host_rsp.bvalid && host_req.bready && host_rsp.bresp !== 2'b00) begin
            err_cnt <= err_cnt + 1;
            $display("FAIL bresp: expected 0, got %h", host_rsp.bresp);
         end
      end
   end

endmodule

// File: verilog/up_controller.sv
`timescale 1ns/1ps

module up_controller (
   input  logic            clk,
   input  logic            nRst,
   input  logic            run,
   input  logic            intr,
   input  up_pkg::nibble_t ir,
   input  logic            eq_flag,
   output up_pkg::ctrl_t   ctrl
);
   import up_pkg::*;

   state_e state;
   state_e state_nx;
   ctrl_t  ctrl_nx;
   logic   int_en;
   logic   int_busy;   // In service
   logic   int_last;
   logic   int_go;
   logic   idle;

   // Edge is held pending until FETCH takes it
   assign int_go = intr & ~int_last & int_en & ~int_busy;
   // Parked in LOAD_REGS_0 with nothing issued yet
   assign idle   = (state == LOAD_REGS_0) && !ctrl.ale;

   function automatic ctrl_t ctrl_for(state_e st, nibble_t op, logic eq);
      ctrl_t c;
      c = '0;
      case (st)
         LOAD_REGS_0: begin
            c.alu_sel = ALU_C0;
            c.ale     = 1'b1;
         end
         LOAD_REGS_1, LOAD_REGS_2, LOAD_REGS_3: begin
            c.alu_sel = (st == LOAD_REGS_1) ? ALU_C1 : (st == LOAD_REGS_2) ? ALU_C2 : ALU_C3;
            c.ale     = 1'b1;
            c.rb_sel  = {1'b0, 2'(st - LOAD_REGS_1)};   // Previous byte into r0..r2
            c.rb_we   = 1'b1;
         end
         LOAD_REGS_4: begin
            c.rb_sel = 3'b011;
            c.rb_we  = 1'b1;
         end
         FETCH: begin
            c.alu_sel = ALU_PC_BYTE;
            c.ale     = 1'b1;
         end
         DECODE: begin
            c.ir_we   = 1'b1;   // Also steps pc
            c.alu_sel = ALU_SP;
            c.ale     = 1'b1;   // Stack slot ready for a call
         end
         EXECUTE_1: begin
            case (op)
               4'h0, 4'h1, 4'h2, 4'h3: begin
                  c.alu_sel = {1'b0, op};
                  c.rb_sel  = 3'b100;   // Result into r0
                  c.rb_we   = 1'b1;
               end
               4'h4, 4'h5, 4'h6: begin
                  c.alu_sel = {1'b0, op};
                  c.rb_sel  = {1'b1, op[1:0]};
                  c.rb_we   = 1'b1;
               end
               4'h7: begin
                  c.alu_sel = ALU_R3;
                  c.pc_we   = eq;
               end
               4'h8, 4'hA: begin
                  c.alu_sel = ALU_SP_INC;
                  c.sp_we   = 1'b1;
                  c.ale     = 1'b1;
               end
               4'h9: begin
                  c.alu_sel = ALU_PC;   // Return nibble
                  c.mem_we  = 1'b1;
               end
               4'hB: begin
                  c.alu_sel = ALU_SP;
                  c.ale     = 1'b1;
               end
               4'hC, 4'hD: begin
                  c.alu_sel = ALU_R3;
                  c.ale     = 1'b1;
               end
               4'hE: begin
                  c.alu_sel = ALU_R0;
                  c.ale     = 1'b1;
               end
               default: ;
            endcase
         end
         EXECUTE_2: begin
            case (op)
               4'h4, 4'h5, 4'h6: begin
                  c.alu_sel = {1'b0, op};
                  c.rb_sel  = {1'b1, op[1:0] + 2'd1};
                  c.rb_we   = 1'b1;
               end
               4'h8: begin
                  c.alu_sel = ALU_MEM;
                  c.pc_we   = 1'b1;
               end
               4'h9: begin
                  c.alu_sel = ALU_SP_DEC;
                  c.sp_we   = 1'b1;
               end
               4'hA, 4'hC: begin
                  c.rb_sel = 3'b010;
                  c.rb_we  = 1'b1;
               end
               4'hB, 4'hD: begin
                  c.alu_sel = ALU_R2;
                  c.mem_we  = 1'b1;
               end
               4'hE: begin
                  c.rb_sel = 3'b000;
                  c.rb_we  = 1'b1;
               end
               default: ;
            endcase
         end
         EXECUTE_3: begin
            case (op)
               4'h4, 4'h5, 4'h6: begin
                  c.alu_sel = {1'b0, op};
                  c.rb_sel  = {1'b1, op[1:0]};
                  c.rb_we   = 1'b1;
               end
               4'h9: begin
                  c.alu_sel = ALU_R3;
                  c.pc_we   = 1'b1;
               end
               4'hB: begin
                  c.alu_sel = ALU_SP_DEC;
                  c.sp_we   = 1'b1;
               end
               default: ;
            endcase
         end
         INT_1: begin
            c.alu_sel = ALU_SP;
            c.ale     = 1'b1;
         end
         INT_2: begin
            c.alu_sel = ALU_PC;   // Interrupted instruction
            c.mem_we  = 1'b1;
         end
         INT_3: begin
            c.alu_sel = ALU_SP_DEC;
            c.sp_we   = 1'b1;
         end
         INT_4: begin
            c.alu_sel = ALU_VECTOR;
            c.pc_we   = 1'b1;
         end
         default: ;
      endcase
      return c;
   endfunction

   always_comb begin
      case (state)
         LOAD_REGS_0: state_nx = idle ? LOAD_REGS_0 : LOAD_REGS_1;
         LOAD_REGS_1: state_nx = LOAD_REGS_2;
         LOAD_REGS_2: state_nx = LOAD_REGS_3;
         LOAD_REGS_3: state_nx = LOAD_REGS_4;
         LOAD_REGS_4: state_nx = FETCH;
         FETCH:       state_nx = int_go ? INT_1 : DECODE;
         DECODE:      state_nx = EXECUTE_1;
         EXECUTE_1: begin
            case (ir)
               4'h0, 4'h1, 4'h2, 4'h3, 4'h7, 4'hF: state_nx = FETCH;
               default:                            state_nx = EXECUTE_2;
            endcase
         end
         EXECUTE_2: begin
            case (ir)
               4'h4, 4'h5, 4'h6, 4'h9, 4'hB: state_nx = EXECUTE_3;
               default:                      state_nx = FETCH;
            endcase
         end
         INT_1:       state_nx = INT_2;
         INT_2:       state_nx = INT_3;
         INT_3:       state_nx = INT_4;
         default:     state_nx = FETCH;   // EXECUTE_3, INT_4
      endcase
      if (!run) begin
         state_nx = LOAD_REGS_0;
      end
      // Control word for the state being entered, ir comes early from decode
      ctrl_nx = run ? ctrl_for(state_nx, ir, eq_flag) : '0;
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= LOAD_REGS_0;
         ctrl     <= '0;
         int_en   <= 1'b0;
         int_busy <= 1'b0;
         int_last <= 1'b0;
      end else begin
         state <= state_nx;
         ctrl  <= ctrl_nx;
         if (!int_go) begin
            int_last <= intr;
         end
         if (state == FETCH && state_nx == INT_1) begin
            int_busy <= 1'b1;
         end
         if (state == EXECUTE_1 && ir == 4'h8) begin
            int_busy <= 1'b0;   // Return ends service
         end
         if (state == EXECUTE_1 && ir == 4'hF) begin
            int_en <= ~int_en;
         end
      end
   end

endmodule

// File: verilog/up_datapath.sv
`timescale 1ns/1ps
`include "up_macros.svh"

module up_datapath (
   input  logic            clk,
   input  logic            nRst,
   input  up_pkg::ctrl_t   ctrl,
   input  up_pkg::byte_t   rd_data,
   output up_pkg::byte_t   result,
   output up_pkg::nibble_t ir,
   output logic            eq_flag
);
   import up_pkg::*;

   byte_t   r0;
   byte_t   r1;
   byte_t   r2;
   byte_t   r3;
   byte_t   pc;
   byte_t   sp;
   nibble_t ir_q;
   nibble_t fetch_nib;
   byte_t   rb_data;

   // Even nibble is the high half
   assign fetch_nib = pc[0] ? rd_data[3:0] : rd_data[7:4];
   // Controller sees the new opcode while it is being loaded
   assign ir        = ctrl.ir_we ? fetch_nib : ir_q;
   assign eq_flag   = (r1 == r2);
   assign rb_data   = ctrl.rb_sel[2] ? result : rd_data;

   always_comb begin
      case (ctrl.alu_sel)
         ALU_ADD:     result = r1 + r2;
         ALU_SUB:     result = r1 - r2;
         ALU_MUL:     result = r1 * r2;   // Low byte
         ALU_NAND:    result = ~(r1 & r2);
         ALU_XOR01:   result = r0 ^ r1;
         ALU_XOR12:   result = r1 ^ r2;
         ALU_XOR23:   result = r2 ^ r3;
         ALU_R0:      result = r0;
         ALU_R2:      result = r2;
         ALU_R3:      result = r3;
         ALU_C0:      result = 8'd0;
         ALU_C1:      result = 8'd1;
         ALU_C2:      result = 8'd2;
         ALU_C3:      result = 8'd3;
         ALU_PC:      result = pc;
         ALU_PC_BYTE: result = {1'b0, pc[7:1]};
         ALU_SP:      result = sp;
         ALU_SP_INC:  result = sp + 8'd1;
         ALU_SP_DEC:  result = sp - 8'd1;
         ALU_VECTOR:  result = `UP_INT_VECTOR;
         default:     result = rd_data;   // ALU_MEM
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         r0   <= '0;
         r1   <= '0;
         r2   <= '0;
         r3   <= '0;
         pc   <= `UP_PC_RESET;
         sp   <= `UP_SP_RESET;
         ir_q <= '0;
      end else begin
         if (ctrl.pc_we) begin
            pc <= result;
         end else if (ctrl.ir_we) begin
            pc <= pc + 8'd1;   // Next nibble
         end
         if (ctrl.ir_we) begin
            ir_q <= fetch_nib;
         end
         if (ctrl.sp_we) begin
            sp <= result;
         end
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel[1:0])
               2'd0: r0 <= rb_data;
               2'd1: r1 <= rb_data;
               2'd2: r2 <= rb_data;
               2'd3: r3 <= rb_data;
            endcase
         end
      end
   end

endmodule

// File: verilog/up_macros.svh
`ifndef UP_MACROS_SVH
`define UP_MACROS_SVH

// Unified code and data memory, in bytes
`define UP_MEM_SIZE     256

// pc counts nibbles, so nibble 8 is byte 4, just past the register image
`define UP_PC_RESET     8'h08

// Stack grows down from the top byte
`define UP_SP_RESET     8'hFF

// Interrupt entry, as a nibble address
`define UP_INT_VECTOR   8'h00

`endif

// File: verilog/up_memory.sv
`timescale 1ns/1ps
`include "up_macros.svh"

module up_memory (
   input  logic              clk,
   input  logic              nRst,
   input  up_pkg::ctrl_t     ctrl,
   input  up_pkg::byte_t     result,
   input  logic              run,
   input  up_pkg::axil_req_t host_req,
   output up_pkg::byte_t     rd_data,
   output up_pkg::axil_rsp_t host_rsp
);
   import up_pkg::*;

   byte_t mem [`UP_MEM_SIZE];
   byte_t addr_latch;
   byte_t rdata_q;
   logic  bvalid_q;
   logic  rvalid_q;
   logic  host_free;
   logic  wr_go;
   logic  rd_go;

   assign rd_data   = mem[addr_latch];
   // Host locked out while the core runs or a response waits
   assign host_free = !run && !bvalid_q && !rvalid_q;
   assign wr_go     = host_free && host_req.awvalid && host_req.wvalid;   // AW and W together
   assign rd_go     = host_free && host_req.arvalid;

   always_comb begin
      host_rsp         = '0;   // OKAY responses
      host_rsp.awready = wr_go;
      host_rsp.wready  = wr_go;
      host_rsp.bvalid  = bvalid_q;
      host_rsp.arready = rd_go;
      host_rsp.rvalid  = rvalid_q;
      host_rsp.rdata   = rdata_q;
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr_latch <= '0;
         bvalid_q   <= 1'b0;
         rvalid_q   <= 1'b0;
      end else begin
         if (ctrl.ale) begin
            addr_latch <= result;
         end
         if (wr_go) begin
            bvalid_q <= 1'b1;
         end else if (host_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (rd_go) begin
            rvalid_q <= 1'b1;
         end else if (host_req.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_go) begin
         rdata_q <= mem[host_req.araddr];
      end
      if (wr_go) begin
         mem[host_req.awaddr] <= host_req.wdata;
      end
      if (ctrl.mem_we) begin
         mem[addr_latch] <= result;   // Core wins a same-cycle clash
      end
   end

endmodule

// File: verilog/up_pkg.sv
package up_pkg;

   typedef logic [7:0] byte_t;
   typedef logic [3:0] nibble_t;
   typedef logic [4:0] alu_sel_t;

   typedef enum logic [3:0] {
      LOAD_REGS_0,
      LOAD_REGS_1,
      LOAD_REGS_2,
      LOAD_REGS_3,
      LOAD_REGS_4,
      FETCH,
      DECODE,
      EXECUTE_1,
      EXECUTE_2,
      EXECUTE_3,
      INT_1,
      INT_2,
      INT_3,
      INT_4
   } state_e;

   // Codes 0-6 line up with opcodes 0-6
   localparam alu_sel_t ALU_ADD     = 5'd0;
   localparam alu_sel_t ALU_SUB     = 5'd1;
   localparam alu_sel_t ALU_MUL     = 5'd2;
   localparam alu_sel_t ALU_NAND    = 5'd3;
   localparam alu_sel_t ALU_XOR01   = 5'd4;
   localparam alu_sel_t ALU_XOR12   = 5'd5;
   localparam alu_sel_t ALU_XOR23   = 5'd6;
   localparam alu_sel_t ALU_R0      = 5'd7;
   localparam alu_sel_t ALU_R2      = 5'd8;
   localparam alu_sel_t ALU_R3      = 5'd9;
   localparam alu_sel_t ALU_C0      = 5'd10;
   localparam alu_sel_t ALU_C1      = 5'd11;
   localparam alu_sel_t ALU_C2      = 5'd12;
   localparam alu_sel_t ALU_C3      = 5'd13;
   localparam alu_sel_t ALU_PC      = 5'd14;
   localparam alu_sel_t ALU_PC_BYTE = 5'd15;   // Byte address of pc
   localparam alu_sel_t ALU_SP      = 5'd16;
   localparam alu_sel_t ALU_SP_INC  = 5'd17;
   localparam alu_sel_t ALU_SP_DEC  = 5'd18;
   localparam alu_sel_t ALU_VECTOR  = 5'd19;
   localparam alu_sel_t ALU_MEM     = 5'd20;

   typedef struct packed {
      alu_sel_t   alu_sel;
      logic       ir_we;
      logic       pc_we;
      logic [2:0] rb_sel;   // Bit 2 picks result over rd_data, [1:0] the register
      logic       rb_we;
      logic       sp_we;
      logic       mem_we;
      logic       ale;
   } ctrl_t;

   typedef struct packed {
      logic  awvalid;
      byte_t awaddr;
      logic  wvalid;
      byte_t wdata;
      logic  bready;
      logic  arvalid;
      byte_t araddr;
      logic  rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
      logic       arready;
      logic       rvalid;
      byte_t      rdata;
      logic [1:0] rresp;
   } axil_rsp_t;

endpackage

// File: verilog/up_top.sv
`timescale 1ns/1ps

module up_top (
   input  logic              clk,
   input  logic              nRst,
   input  logic              run,
   input  logic              intr,
   input  up_pkg::axil_req_t host_req,
   output up_pkg::axil_rsp_t host_rsp
);
   import up_pkg::*;

   ctrl_t   ctrl;
   byte_t   result;
   byte_t   rd_data;
   nibble_t ir;
   logic    eq_flag;

   up_controller u_controller (
      .clk     (clk),
      .nRst    (nRst),
      .run     (run),
      .intr    (intr),
      .ir      (ir),
      .eq_flag (eq_flag),
      .ctrl    (ctrl)
   );

   up_datapath u_datapath (
      .clk     (clk),
      .nRst    (nRst),
      .ctrl    (ctrl),
      .rd_data (rd_data),
      .result  (result),
      .ir      (ir),
      .eq_flag (eq_flag)
   );

   up_memory u_memory (
      .clk      (clk),
      .nRst     (nRst),
      .ctrl     (ctrl),
      .result   (result),
      .run      (run),
      .host_req (host_req),
      .rd_data  (rd_data),
      .host_rsp (host_rsp)
   );

endmodule
